// File: arbiter_rr.sv
`timescale 1ns/100ps

module arbiter_rr (
    input  logic                       clock,
    input  logic                       rst,
    input  logic [lq_pkg::LQ_SIZE-1:0] req,
    output logic [lq_pkg::LQ_SIZE-1:0] gnt
);
    import lq_pkg::*;

    // position granted most recently
    logic [LQ_IDX_W-1:0] last;
    logic [LQ_IDX_W-1:0] idx;
    logic [LQ_IDX_W-1:0] gnt_idx;
    logic                found;

    // search starts one above last, wraps through last itself
    always_comb begin
        gnt     = '0;
        gnt_idx = last;
        found   = 1'b0;
        idx     = last;
        for (int i = 1; i <= LQ_SIZE; i++) begin
            idx = last + LQ_IDX_W'(i);
            if (!found && req[idx]) begin
                gnt[idx] = 1'b1;
                gnt_idx  = idx;
                found    = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            // entry 0 gets first priority out of reset
            last <= LQ_IDX_W'(LQ_SIZE - 1);
        end else if (found) begin
            last <= gnt_idx;
        end
    end

    a_gnt_onehot: assert property (@(posedge clock) disable iff (rst)
        $onehot0(gnt) && ((gnt & ~req) == '0))
        else $error("arbiter grant not one-hot or not requested");

endmodule

// File: load_queue.f
lq_pkg.sv
arbiter_rr.sv
lq_store_check.sv
lq_entries.sv
lq_cdb_out.sv
load_queue.sv
lq_checker.sv
tb_load_queue.sv

// File: load_queue.sv
`timescale 1ns/100ps

module load_queue (
    input  logic                                    clock,
    input  logic                                    rst,
    input  logic                                    except,
    input  lq_pkg::load_alloc_t                     alloc,
    input  lq_pkg::alu_addr_t                       alu,
    input  lq_pkg::sq_entry_t [lq_pkg::SQ_SIZE-1:0] sq,
    input  logic [lq_pkg::SQ_IDX_W-1:0]             sq_head,
    input  logic                                    dc_hit,
    input  logic [lq_pkg::DATA_W-1:0]               dc_data,
    input  lq_pkg::mem_resp_t                       mem,
    output lq_pkg::dcache_req_t                     dc_req,
    output lq_pkg::cdb_packet_t                     cdb,
    output logic [lq_pkg::LQ_IDX_W:0]               num_free
);
    import lq_pkg::*;

    lq_entry_t [LQ_SIZE-1:0]             entries;
    logic [LQ_SIZE-1:0]                  blocked;
    logic [LQ_SIZE-1:0]                  forward;
    logic [LQ_SIZE-1:0][DATA_W-1:0]      fwd_data;
    logic [LQ_SIZE-1:0]                  cdb_gnt;

    lq_entries u_entries (
        .clock    (clock),
        .rst      (rst),
        .except   (except),
        .alloc    (alloc),
        .alu      (alu),
        .blocked  (blocked),
        .forward  (forward),
        .fwd_data (fwd_data),
        .cdb_gnt  (cdb_gnt),
        .dc_hit   (dc_hit),
        .dc_data  (dc_data),
        .mem      (mem),
        .entries  (entries),
        .dc_req   (dc_req),
        .num_free (num_free)
    );

    // one store check per load entry
    for (genvar g = 0; g < LQ_SIZE; g++) begin : g_check
        lq_store_check u_check (
            .entry    (entries[g]),
            .sq       (sq),
            .sq_head  (sq_head),
            .blocked  (blocked[g]),
            .forward  (forward[g]),
            .fwd_data (fwd_data[g])
        );
    end

    lq_cdb_out u_cdb_out (
        .clock   (clock),
        .rst     (rst),
        .entries (entries),
        .cdb     (cdb),
        .cdb_gnt (cdb_gnt)
    );

endmodule

// File: lq_cdb_out.sv
`timescale 1ns/100ps

module lq_cdb_out (
    input  logic                                    clock,
    input  logic                                    rst,
    input  lq_pkg::lq_entry_t [lq_pkg::LQ_SIZE-1:0] entries,
    output lq_pkg::cdb_packet_t                     cdb,
    output logic [lq_pkg::LQ_SIZE-1:0]              cdb_gnt
);
    import lq_pkg::*;

    logic [LQ_SIZE-1:0] done_req;
    lq_entry_t          sel;
    load_word_u         raw;

    always_comb begin
        for (int i = 0; i < LQ_SIZE; i++) begin
            done_req[i] = entries[i].busy && (entries[i].state == DONE);
        end
    end

    arbiter_rr u_cdb_arb (
        .clock (clock),
        .rst   (rst),
        .req   (done_req),
        .gnt   (cdb_gnt)
    );

    // grant is one-hot, so a plain select
    always_comb begin
        sel = '0;
        for (int i = 0; i < LQ_SIZE; i++) begin
            if (cdb_gnt[i])
                sel = entries[i];
        end
    end

    assign raw = sel.data;

    always_comb begin
        cdb.valid   = |cdb_gnt;
        cdb.rob_idx = sel.rob_idx;
        cdb.prf_idx = sel.prf_idx;
        case (sel.size)
            BYTE: cdb.data = {{24{sel.is_signed & raw.bytes[0][7]}}, raw.bytes[0]};
            HALF: cdb.data = {{16{sel.is_signed & raw.halves[0][15]}}, raw.halves[0]};
            // full words pass unchanged
            default: cdb.data = raw.word;
        endcase
    end

endmodule

// File: lq_checker.sv
`timescale 1ns/100ps

module lq_checker (
    input  logic                                    clock,
    input  logic                                    rst,
    input  logic                                    except,
    input  lq_pkg::load_alloc_t                     alloc,
    input  lq_pkg::alu_addr_t                       alu,
    input  lq_pkg::sq_entry_t [lq_pkg::SQ_SIZE-1:0] sq,
    input  logic [lq_pkg::SQ_IDX_W-1:0]             sq_head,
    input  lq_pkg::dcache_req_t                     dc_req,
    input  lq_pkg::cdb_packet_t                     cdb,
    input  logic [8*12-1:0]                         test_name,
    output int                                      errors,
    output int                                      checks,
    output int                                      outstanding
);
    import lq_pkg::*;

    // one record per ROB tag filled at dispatch and at address time
    logic              pending  [2**ROB_IDX_W];
    logic              has_addr [2**ROB_IDX_W];
    load_alloc_t       info     [2**ROB_IDX_W];
    logic [ADDR_W-1:0] ld_addr  [2**ROB_IDX_W];

    initial begin
        errors = 0;
        checks = 0;
    end

    // memory contents as a function of the word address
    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
        return ({18'd0, addr[ADDR_W-1:2]} * 32'h0001_0193) ^ 32'h8c4e_97b1;
    endfunction

    function automatic logic [DATA_W-1:0] expect_load(
        input  sq_entry_t [SQ_SIZE-1:0] stores,
        input  logic [SQ_IDX_W-1:0]     head,
        input  load_alloc_t             ld,
        input  logic [ADDR_W-1:0]       addr,
        output logic                    early
    );
        logic [SQ_IDX_W-1:0] slot;
        logic [DATA_W-1:0]   raw;
        logic                found;
        int                  n_older;
        raw     = fill_word(addr);
        early   = 1'b0;
        found   = 1'b0;
        n_older = (int'(ld.sq_tail) - int'(head) + SQ_SIZE) % SQ_SIZE;
        // youngest older store first
        for (int k = 1; k <= n_older; k++) begin
            slot = ld.sq_tail - SQ_IDX_W'(k);
            if (!found && stores[slot].addr_valid &&
                stores[slot].addr[ADDR_W-1:BLOCK_OFS_W] == addr[ADDR_W-1:BLOCK_OFS_W]) begin
                found = 1'b1;
                raw   = stores[slot].data;
                // only a full match with data may complete
                early = !stores[slot].data_valid || (stores[slot].size != ld.size) ||
                        (stores[slot].addr[BLOCK_OFS_W-1:0] != addr[BLOCK_OFS_W-1:0]);
            end
        end
        case (ld.size)
            BYTE:    return {{24{ld.is_signed & raw[7]}}, raw[7:0]};
            HALF:    return {{16{ld.is_signed & raw[15]}}, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    // a cache read must belong to a pending load with a known address
    function automatic logic cache_read_known(input dcache_req_t req);
        for (int r = 0; r < 2**ROB_IDX_W; r++) begin
            if (pending[r] && has_addr[r] && (ld_addr[r] == req.addr) &&
                (info[r].size == req.size))
                return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic void clear_pending();
        for (int r = 0; r < 2**ROB_IDX_W; r++) begin
            pending[r]  = 1'b0;
            has_addr[r] = 1'b0;
        end
        outstanding = 0;
    endfunction

    always @(posedge clock) begin : compare
        logic              early;
        logic [DATA_W-1:0] exp_data;
        if (rst) begin
            clear_pending();
        end else begin
            if (dc_req.valid && !cache_read_known(dc_req)) begin
                errors++;
                $display("cache read in test %0s for address %h size %0d matches no pending load",
                         test_name, dc_req.addr, dc_req.size);
            end
            if (cdb.valid && !pending[cdb.rob_idx]) begin
                errors++;
                $display("ROB %0d broadcast in test %0s with no load pending",
                         cdb.rob_idx, test_name);
            end else if (cdb.valid) begin
                exp_data = expect_load(sq, sq_head, info[cdb.rob_idx], ld_addr[cdb.rob_idx],
                                       early);
                checks++;
                if (early) begin
                    errors++;
                    $display("ROB %0d in test %0s broadcast while an older store blocked it",
                             cdb.rob_idx, test_name);
                end
                if (cdb.data !== exp_data) begin
                    errors++;
                    $display("error %0s: ROB %0d data expected %h actual %h",
                             test_name, cdb.rob_idx, exp_data, cdb.data);
                end
                if (cdb.prf_idx !== info[cdb.rob_idx].prf_idx) begin
                    errors++;
                    $display("error %0s: ROB %0d prf expected %h actual %h",
                             test_name, cdb.rob_idx, info[cdb.rob_idx].prf_idx, cdb.prf_idx);
                end
                pending[cdb.rob_idx] = 1'b0;
                outstanding--;
            end
            if (alloc.valid) begin
                pending[alloc.rob_idx]  = 1'b1;
                has_addr[alloc.rob_idx] = 1'b0;
                info[alloc.rob_idx]     = alloc;
                outstanding++;
            end
            if (alu.valid && pending[alu.rob_idx] && !has_addr[alu.rob_idx]) begin
                ld_addr[alu.rob_idx]  = alu.addr;
                has_addr[alu.rob_idx] = 1'b1;
            end
            // a flush drops every load in flight
            if (except)
                clear_pending();
        end
    end

endmodule

// File: lq_entries.sv
`timescale 1ns/100ps

module lq_entries (
    input  logic                                          clock,
    input  logic                                          rst,
    input  logic                                          except,
    input  lq_pkg::load_alloc_t                           alloc,
    input  lq_pkg::alu_addr_t                             alu,
    input  logic [lq_pkg::LQ_SIZE-1:0]                    blocked,
    input  logic [lq_pkg::LQ_SIZE-1:0]                    forward,
    input  logic [lq_pkg::LQ_SIZE-1:0][lq_pkg::DATA_W-1:0] fwd_data,
    input  logic [lq_pkg::LQ_SIZE-1:0]                    cdb_gnt,
    input  logic                                          dc_hit,
    input  logic [lq_pkg::DATA_W-1:0]                     dc_data,
    input  lq_pkg::mem_resp_t                             mem,
    output lq_pkg::lq_entry_t [lq_pkg::LQ_SIZE-1:0]       entries,
    output lq_pkg::dcache_req_t                           dc_req,
    output logic [lq_pkg::LQ_IDX_W:0]                     num_free
);
    import lq_pkg::*;

    logic [LQ_SIZE-1:0] alloc_gnt;
    logic               alloc_hit;
    logic               alloc_take;
    logic               cdb_free;
    logic [LQ_SIZE-1:0] alu_hit;
    logic [LQ_SIZE-1:0] ready_vec;
    logic [LQ_SIZE-1:0] done_vec;
    logic [LQ_SIZE-1:0] cache_gnt;

    // lowest free entry takes the load
    always_comb begin
        alloc_gnt = '0;
        alloc_hit = 1'b0;
        for (int i = 0; i < LQ_SIZE; i++) begin
            if (!alloc_hit && !entries[i].busy) begin
                alloc_gnt[i] = alloc.valid;
                alloc_hit    = 1'b1;
            end
        end
    end

    assign alloc_take = alloc.valid && alloc_hit;
    assign cdb_free   = |cdb_gnt;

    always_comb begin
        for (int i = 0; i < LQ_SIZE; i++) begin
            alu_hit[i]   = alu.valid && entries[i].busy && !entries[i].addr_ready &&
                           (alu.rob_idx == entries[i].rob_idx);
            ready_vec[i] = entries[i].busy && (entries[i].state == READY_CACHE);
            done_vec[i]  = entries[i].busy && (entries[i].state == DONE);
        end
    end

    arbiter_rr u_cache_arb (
        .clock (clock),
        .rst   (rst),
        .req   (ready_vec),
        .gnt   (cache_gnt)
    );

    // one read per cycle, answered in the same cycle
    always_comb begin
        dc_req = '0;
        for (int i = 0; i < LQ_SIZE; i++) begin
            if (cache_gnt[i]) begin
                dc_req.valid  = 1'b1;
                dc_req.addr   = entries[i].addr;
                dc_req.size   = entries[i].size;
                dc_req.lq_idx = LQ_IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst || except) begin
            for (int i = 0; i < LQ_SIZE; i++) begin
                entries[i].busy       <= 1'b0;
                entries[i].state      <= WAIT_ADDR;
                entries[i].addr_ready <= 1'b0;
            end
            num_free <= (LQ_IDX_W + 1)'(LQ_SIZE);
        end else begin
            for (int i = 0; i < LQ_SIZE; i++) begin
                if (cdb_gnt[i]) begin
                    entries[i].busy       <= 1'b0;
                    entries[i].state      <= WAIT_ADDR;
                    entries[i].addr_ready <= 1'b0;
                end else if (alloc_gnt[i]) begin
                    entries[i].busy       <= 1'b1;
                    entries[i].state      <= WAIT_ADDR;
                    entries[i].addr_ready <= 1'b0;
                    entries[i].size       <= alloc.size;
                    entries[i].is_signed  <= alloc.is_signed;
                    entries[i].rob_idx    <= alloc.rob_idx;
                    entries[i].prf_idx    <= alloc.prf_idx;
                    entries[i].sq_tail    <= alloc.sq_tail;
                end else if (entries[i].busy) begin
                    if (alu_hit[i]) begin
                        entries[i].addr       <= alu.addr;
                        entries[i].addr_ready <= 1'b1;
                    end
                    case (entries[i].state)
                        WAIT_ADDR: begin
                            if (entries[i].addr_ready && forward[i]) begin
                                entries[i].state <= DONE;
                                entries[i].data  <= fwd_data[i];
                            end else if (entries[i].addr_ready && !blocked[i]) begin
                                entries[i].state <= READY_CACHE;
                            end
                        end
                        READY_CACHE: begin
                            if (cache_gnt[i] && dc_hit) begin
                                entries[i].state <= DONE;
                                entries[i].data  <= dc_data;
                            end else if (cache_gnt[i]) begin
                                entries[i].state <= WAIT_MEM;
                            end
                        end
                        WAIT_MEM: begin
                            // fill tagged with this entry index
                            if (mem.valid && (mem.lq_idx == LQ_IDX_W'(i))) begin
                                entries[i].state <= DONE;
                                entries[i].data  <= mem.data;
                            end
                        end
                        default: begin
                            // held until the CDB takes it
                            entries[i].state <= DONE;
                        end
                    endcase
                end
            end
            num_free <= num_free - (LQ_IDX_W + 1)'(alloc_take) + (LQ_IDX_W + 1)'(cdb_free);
        end
    end

    a_no_alloc_full: assert property (@(posedge clock) disable iff (rst)
        alloc.valid |-> (num_free != '0))
        else $error("load dispatched while queue full");

    a_cdb_done_only: assert property (@(posedge clock) disable iff (rst)
        (cdb_gnt & ~done_vec) == '0)
        else $error("CDB granted an entry that is not done");

endmodule

// File: lq_pkg.sv
package lq_pkg;

    // queue and store-queue geometry
    localparam int LQ_SIZE     = 8;
    localparam int SQ_SIZE     = 8;
    localparam int LQ_IDX_W    = 3;
    localparam int SQ_IDX_W    = 3;

    // tag and datapath widths
    localparam int ROB_IDX_W   = 5;
    localparam int PRF_IDX_W   = 6;
    localparam int ADDR_W      = 16;
    localparam int DATA_W      = 32;
    // offset bits inside an 8-byte block
    localparam int BLOCK_OFS_W = 3;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_t;

    typedef enum logic [1:0] {
        WAIT_ADDR   = 2'd0,
        READY_CACHE = 2'd1,
        WAIT_MEM    = 2'd2,
        DONE        = 2'd3
    } lq_state_t;

    typedef struct packed {
        logic                 valid;
        mem_size_t            size;
        logic                 is_signed;
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [PRF_IDX_W-1:0] prf_idx;
        // store-queue tail seen at dispatch
        logic [SQ_IDX_W-1:0]  sq_tail;
    } load_alloc_t;

    typedef struct packed {
        logic                 valid;
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [ADDR_W-1:0]    addr;
    } alu_addr_t;

    typedef struct packed {
        logic [ADDR_W-1:0]    addr;
        mem_size_t            size;
        logic [DATA_W-1:0]    data;
        logic                 addr_valid;
        logic                 data_valid;
    } sq_entry_t;

    typedef struct packed {
        logic                 busy;
        lq_state_t            state;
        mem_size_t            size;
        logic                 is_signed;
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [PRF_IDX_W-1:0] prf_idx;
        logic [ADDR_W-1:0]    addr;
        logic                 addr_ready;
        logic [SQ_IDX_W-1:0]  sq_tail;
        logic [DATA_W-1:0]    data;
    } lq_entry_t;

    typedef struct packed {
        logic                 valid;
        logic [ADDR_W-1:0]    addr;
        mem_size_t            size;
        logic [LQ_IDX_W-1:0]  lq_idx;
    } dcache_req_t;

    typedef struct packed {
        logic                 valid;
        logic [LQ_IDX_W-1:0]  lq_idx;
        logic [DATA_W-1:0]    data;
    } mem_resp_t;

    typedef struct packed {
        logic                 valid;
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [PRF_IDX_W-1:0] prf_idx;
        logic [DATA_W-1:0]    data;
    } cdb_packet_t;

    // load word as seen by the extension logic
    typedef union packed {
        logic [DATA_W-1:0]   word;
        logic [1:0][15:0]    halves;
        logic [3:0][7:0]     bytes;
    } load_word_u;

endpackage

// File: lq_store_check.sv
`timescale 1ns/100ps

module lq_store_check (
    input  lq_pkg::lq_entry_t                       entry,
    input  lq_pkg::sq_entry_t [lq_pkg::SQ_SIZE-1:0] sq,
    input  logic [lq_pkg::SQ_IDX_W-1:0]             sq_head,
    output logic                                    blocked,
    output logic                                    forward,
    output logic [lq_pkg::DATA_W-1:0]               fwd_data
);
    import lq_pkg::*;

    logic                wrap;
    logic [SQ_SIZE-1:0]  older;
    logic [SQ_SIZE-1:0]  same_blk;
    logic [SQ_IDX_W-1:0] j;
    logic [SQ_IDX_W-1:0] sel;
    logic                found;
    logic                match;
    logic                active;

    // store tail wrapped below head since dispatch
    assign wrap = sq_head > entry.sq_tail;

    // older stores sit in [head, tail)
    always_comb begin
        for (int i = 0; i < SQ_SIZE; i++) begin
            if (wrap)
                older[i] = (SQ_IDX_W'(i) < entry.sq_tail) || (SQ_IDX_W'(i) >= sq_head);
            else
                older[i] = (SQ_IDX_W'(i) < entry.sq_tail) && (SQ_IDX_W'(i) >= sq_head);
            same_blk[i] = older[i] && sq[i].addr_valid &&
                          (sq[i].addr[ADDR_W-1:BLOCK_OFS_W] ==
                           entry.addr[ADDR_W-1:BLOCK_OFS_W]);
        end
    end

    // walk oldest to youngest, the last hit is the youngest store
    always_comb begin
        sel   = sq_head;
        found = 1'b0;
        j     = sq_head;
        for (int k = 0; k < SQ_SIZE; k++) begin
            j = sq_head + SQ_IDX_W'(k);
            if (same_blk[j]) begin
                sel   = j;
                found = 1'b1;
            end
        end
    end

    assign match = (sq[sel].addr[BLOCK_OFS_W-1:0] == entry.addr[BLOCK_OFS_W-1:0]) &&
                   (sq[sel].size == entry.size) && sq[sel].data_valid;

    // nothing to check until the address is known
    assign active = entry.busy && entry.addr_ready;

    assign forward  = active && found && match;
    // partial overlap or data not yet there
    assign blocked  = active && found && !match;
    assign fwd_data = sq[sel].data;

endmodule

// File: tb_load_queue.sv
`timescale 1ns/100ps

module tb_load_queue;
    import lq_pkg::*;

    logic                    clock;
    logic                    rst;
    logic                    except;
    load_alloc_t             alloc;
    alu_addr_t               alu;
    sq_entry_t [SQ_SIZE-1:0] sq;
    logic [SQ_IDX_W-1:0]     sq_head;
    logic                    dc_hit;
    logic [DATA_W-1:0]       dc_data;
    mem_resp_t               mem;
    dcache_req_t             dc_req;
    cdb_packet_t             cdb;
    logic [LQ_IDX_W:0]       num_free;
    logic [8*12-1:0]         test_name;
    int                      errors;
    int                      checks;
    int                      outstanding;
    int                      tb_errors;
    int                      seed;
    int                      rob_next;
    // cycles left until each entry's memory fill
    int                      mem_wait [LQ_SIZE];
    logic [ADDR_W-1:0]       mem_addr [LQ_SIZE];

    load_queue uut (.*);

    lq_checker chk (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [DATA_W-1:0] cache_word(input logic [ADDR_W-1:0] addr);
        return ({18'd0, addr[ADDR_W-1:2]} * 32'h0001_0193) ^ 32'h8c4e_97b1;
    endfunction

    // bit 3 set means the cache misses
    function automatic logic [ADDR_W-1:0] rand_addr(input logic miss);
        logic [ADDR_W-1:0] a;
        a    = ADDR_W'($random(seed));
        a[3] = miss;
        return a;
    endfunction

    // cache answers the current request and memory fills three cycles after a miss
    always @(negedge clock) begin
        mem = '0;
        for (int i = 0; i < LQ_SIZE; i++) begin
            if (mem_wait[i] > 0) begin
                mem_wait[i]--;
                if (mem_wait[i] == 0) begin
                    mem.valid  = 1'b1;
                    mem.lq_idx = LQ_IDX_W'(i);
                    mem.data   = cache_word(mem_addr[i]);
                end
            end
        end
        dc_hit  = dc_req.valid && !dc_req.addr[3];
        dc_data = cache_word(dc_req.addr);
        if (dc_req.valid && dc_req.addr[3]) begin
            mem_wait[dc_req.lq_idx] = 3;
            mem_addr[dc_req.lq_idx] = dc_req.addr;
        end
    end

    // reset or flush drops every fill in flight
    always @(posedge clock) begin
        if (rst || except) begin
            for (int i = 0; i < LQ_SIZE; i++)
                mem_wait[i] = 0;
        end
    end

    task automatic abort_run(input string what);
        $display("timeout waiting for %s in test %0s", what, test_name);
        $display("Test failed");
        $finish;
    endtask

    task automatic dispatch(input mem_size_t size, input logic sgn, input int tail);
        int n;
        n = 0;
        @(negedge clock);
        while (num_free == 0) begin
            n++;
            if (n > 200)
                abort_run("a free load queue entry");
            @(negedge clock);
        end
        alloc.valid     = 1'b1;
        alloc.size      = size;
        alloc.is_signed = sgn;
        alloc.rob_idx   = ROB_IDX_W'(rob_next);
        alloc.prf_idx   = PRF_IDX_W'(rob_next) ^ 6'h2a;
        alloc.sq_tail   = SQ_IDX_W'(tail);
        @(negedge clock);
        alloc.valid = 1'b0;
        rob_next++;
    endtask

    task automatic send_addr(input int rob, input logic [ADDR_W-1:0] addr);
        @(negedge clock);
        alu.valid   = 1'b1;
        alu.rob_idx = ROB_IDX_W'(rob);
        alu.addr    = addr;
        @(negedge clock);
        alu.valid = 1'b0;
    endtask

    task automatic set_store(input int slot, input logic [ADDR_W-1:0] addr,
                             input mem_size_t size, input logic [DATA_W-1:0] data,
                             input logic data_valid);
        sq[slot].addr       = addr;
        sq[slot].size       = size;
        sq[slot].data       = data;
        sq[slot].addr_valid = 1'b1;
        sq[slot].data_valid = data_valid;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge clock);
        while (outstanding != 0 || num_free != LQ_SIZE) begin
            n++;
            if (n > 300)
                abort_run("the queue to drain");
            @(negedge clock);
        end
    endtask

    initial begin
        int base;
        seed      = 32'h5775_07ac;
        rst       = 1'b1;
        except    = 1'b0;
        alloc     = '0;
        alu       = '0;
        sq        = '0;
        sq_head   = '0;
        dc_hit    = 1'b0;
        dc_data   = '0;
        mem       = '0;
        tb_errors = 0;
        rob_next  = 0;
        test_name = "reset";
        repeat (8) @(negedge clock);
        rst = 1'b0;

        // hits and misses with no older stores
        test_name = "plain";
        base = rob_next;
        for (int i = 0; i < 4; i++)
            dispatch(WORD, 1'b0, 0);
        for (int i = 0; i < 4; i++)
            send_addr(base + i, rand_addr(i[0]));
        wait_drain();

        // wrapped store queue with older stores in slots 6, 7, 0 and 1
        test_name = "forward";
        sq_head = 3'd6;
        set_store(6, 16'h731a, HALF, 32'hdead_8765, 1'b1);
        set_store(7, 16'h4a20, WORD, 32'h1111_2222, 1'b1);
        set_store(0, 16'h0f40, WORD, 32'h3333_4444, 1'b1);
        set_store(1, 16'h4a20, WORD, 32'h9abc_def0, 1'b1);
        base = rob_next;
        dispatch(WORD, 1'b0, 2);
        dispatch(HALF, 1'b1, 2);
        dispatch(WORD, 1'b0, 7);
        send_addr(base, 16'h4a20);
        send_addr(base + 1, 16'h731a);
        send_addr(base + 2, 16'h4a24);
        wait_drain();

        test_name = "stall";
        sq      = '0;
        sq_head = '0;
        set_store(0, 16'h2c80, WORD, 32'h5a5a_c3c3, 1'b0);
        base = rob_next;
        dispatch(WORD, 1'b0, 1);
        send_addr(base, 16'h2c80);
        repeat (20) @(negedge clock);
        if (outstanding != 1) begin
            tb_errors++;
            $display("load in test %0s finished before its store data was valid", test_name);
        end
        sq[0].data_valid = 1'b1;
        wait_drain();

        test_name = "extend";
        sq = '0;
        base = rob_next;
        for (int i = 0; i < 8; i++)
            dispatch(i[1] ? HALF : BYTE, i[0], 0);
        for (int i = 0; i < 8; i++)
            send_addr(base + i, rand_addr(i[2]));
        wait_drain();

        test_name = "fill";
        base = rob_next;
        for (int i = 0; i < 8; i++)
            dispatch(WORD, 1'b0, 0);
        if (num_free != 0) begin
            tb_errors++;
            $display("error %0s: num_free expected 0 actual %0d", test_name, num_free);
        end
        for (int i = 0; i < 8; i++)
            send_addr(base + i, rand_addr(i[0]));
        wait_drain();

        // flush with loads still waiting for addresses
        test_name = "flush";
        base = rob_next;
        for (int i = 0; i < 3; i++)
            dispatch(WORD, 1'b0, 0);
        @(negedge clock);
        except = 1'b1;
        repeat (2) @(negedge clock);
        except = 1'b0;
        for (int i = 0; i < 3; i++)
            send_addr(base + i, rand_addr(1'b0));
        repeat (20) @(negedge clock);
        if (num_free != LQ_SIZE) begin
            tb_errors++;
            $display("error %0s: num_free expected %0d actual %0d",
                     test_name, LQ_SIZE, num_free);
        end

        if (checks != 24) begin
            tb_errors++;
            $display("error %0s: broadcasts expected 24 actual %0d", test_name, checks);
        end
        $display("errors: %0d in checker, %0d in testbench, %0d broadcasts checked",
                 errors, tb_errors, checks);
        if (errors == 0 && tb_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule
